// ==== include/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath and register file
`define XLEN 64
`define NREGS 32
`define REG_AW 5

// Immediate field, sign-extended at issue
`define IMM_W 12

// Iterative multiplier
`define MUL_BITS 4
`define MUL_CYCLES (`XLEN / `MUL_BITS)

`endif

// ==== rtl/cpu_core.sv ====
`include "cpu_config.svh"

module cpu_core (
    input  logic               clk,
    input  logic               rst,
    // Decoded operation in
    input  logic               op_valid,
    output logic               op_ready,
    input  logic [3:0]         op_code,
    input  logic [`REG_AW-1:0] op_rd,
    input  logic [`REG_AW-1:0] op_rs1,
    input  logic [`REG_AW-1:0] op_rs2,
    input  logic [`IMM_W-1:0]  op_imm,
    input  logic               op_use_imm,
    // Register writes out
    output logic               retire_valid,
    output logic [`REG_AW-1:0] retire_dst,
    output logic [`XLEN-1:0]   retire_data
);
    import cpu_pkg::*;

    opcode_e   op_code_e;
    reg_idx_t  rf_rs1;
    reg_idx_t  rf_rs2;
    xdata_t    rf_rdata1;
    xdata_t    rf_rdata2;
    rf_write_t rf_wr;

    fu_issue_if alu_req ();
    fu_issue_if mul_req ();
    fu_wb_if    alu_wb ();
    fu_wb_if    mul_wb ();

    assign op_code_e = opcode_e'(op_code);

    regfile rf0 (
        .clk(clk),
        .rst(rst),
        .rs1(rf_rs1),
        .rs2(rf_rs2),
        .rdata1(rf_rdata1),
        .rdata2(rf_rdata2),
        .wr(rf_wr)
    );

    issue ix0 (
        .clk(clk),
        .rst(rst),
        .op_valid(op_valid),
        .op_ready(op_ready),
        .op_code(op_code_e),
        .op_rd(op_rd),
        .op_rs1(op_rs1),
        .op_rs2(op_rs2),
        .op_imm(op_imm),
        .op_use_imm(op_use_imm),
        .rs1(rf_rs1),
        .rs2(rf_rs2),
        .rdata1(rf_rdata1),
        .rdata2(rf_rdata2),
        .wr(rf_wr),
        .alu(alu_req.issue),
        .mul(mul_req.issue)
    );

    int_pipe ip0 (.clk(clk), .rst(rst), .req(alu_req.unit), .wb(alu_wb.unit));

    muldiv md0 (.clk(clk), .rst(rst), .req(mul_req.unit), .wb(mul_wb.unit));

    wb_arbiter wb0 (.mul_wb(mul_wb.arbiter), .alu_wb(alu_wb.arbiter), .wr(rf_wr));

    // Every register write is visible outside
    assign retire_valid = rf_wr.en;
    assign retire_dst   = rf_wr.dst;
    assign retire_data  = rf_wr.data;

endmodule

// ==== rtl/cpu_pkg.sv ====
`include "cpu_config.svh"

package cpu_pkg;

    // Operation codes, anything but op_mul goes to the integer pipe
    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_and = 4'd2,
        op_or  = 4'd3,
        op_xor = 4'd4,
        op_sll = 4'd5,
        op_srl = 4'd6,
        op_mul = 4'd7
    } opcode_e;

    typedef logic [`REG_AW-1:0] reg_idx_t;

    typedef logic [`XLEN-1:0] xdata_t;

    // Register file write port
    typedef struct packed {
        logic     en;
        reg_idx_t dst;
        xdata_t   data;
    } rf_write_t;

endpackage

// ==== rtl/fu_if.sv ====
// Issue to functional unit dispatch
interface fu_issue_if;
    import cpu_pkg::*;

    logic     valid;
    logic     ready;
    opcode_e  op;
    reg_idx_t dst;
    xdata_t   operand_a;
    xdata_t   operand_b;

    modport issue (output valid, op, dst, operand_a, operand_b, input ready);
    modport unit (input valid, op, dst, operand_a, operand_b, output ready);
endinterface

// Functional unit to writeback arbiter
interface fu_wb_if;
    import cpu_pkg::*;

    logic     valid;
    logic     ready;
    reg_idx_t dst;
    xdata_t   result;

    modport unit (output valid, dst, result, input ready);
    modport arbiter (input valid, dst, result, output ready);
endinterface

// ==== rtl/int_pipe.sv ====
module int_pipe (
    input  logic      clk,
    input  logic      rst,
    fu_issue_if.unit  req,
    fu_wb_if.unit     wb
);
    import cpu_pkg::*;

    logic       out_valid;
    reg_idx_t   out_dst;
    xdata_t     out_result;
    xdata_t     alu_result;
    logic [5:0] shamt;

    // Free slot, or the held result leaves this cycle
    assign req.ready = !out_valid || wb.ready;

    assign shamt = req.operand_b[5:0];

    always_comb begin
        case (req.op)
            op_add:  alu_result = req.operand_a + req.operand_b;
            op_sub:  alu_result = req.operand_a - req.operand_b;
            op_and:  alu_result = req.operand_a & req.operand_b;
            op_or:   alu_result = req.operand_a | req.operand_b;
            op_xor:  alu_result = req.operand_a ^ req.operand_b;
            op_sll:  alu_result = req.operand_a << shamt;
            op_srl:  alu_result = req.operand_a >> shamt;
            // op_mul never routed here
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (req.ready) begin
            out_valid <= req.valid;
        end
    end

    // Output register holds while waiting for a grant
    always_ff @(posedge clk) begin
        if (req.valid && req.ready) begin
            out_dst    <= req.dst;
            out_result <= alu_result;
        end
    end

    assign wb.valid  = out_valid;
    assign wb.dst    = out_dst;
    assign wb.result = out_result;

endmodule

// ==== rtl/issue.sv ====
`include "cpu_config.svh"

module issue (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  op_valid,
    output logic                  op_ready,
    input  cpu_pkg::opcode_e      op_code,
    input  cpu_pkg::reg_idx_t     op_rd,
    input  cpu_pkg::reg_idx_t     op_rs1,
    input  cpu_pkg::reg_idx_t     op_rs2,
    input  logic [`IMM_W-1:0]     op_imm,
    input  logic                  op_use_imm,
    output cpu_pkg::reg_idx_t     rs1,
    output cpu_pkg::reg_idx_t     rs2,
    input  cpu_pkg::xdata_t       rdata1,
    input  cpu_pkg::xdata_t       rdata2,
    input  cpu_pkg::rf_write_t    wr,
    fu_issue_if.issue             alu,
    fu_issue_if.issue             mul
);
    import cpu_pkg::*;

    logic [`NREGS-1:0] busy;
    logic [`NREGS-1:0] clr_mask;
    logic [`NREGS-1:0] set_mask;
    logic [`NREGS-1:0] busy_now;
    logic              is_mul;
    logic              hazard;
    logic              unit_ready;
    logic              accept;
    xdata_t            imm_ext;
    xdata_t            operand_b;

    // A register retiring this cycle no longer counts as busy
    always_comb begin
        clr_mask = '0;
        if (wr.en) begin
            clr_mask[wr.dst] = 1'b1;
        end
    end

    assign busy_now = busy & ~clr_mask;

    // rs2 is only a source when the immediate is not used
    assign hazard = busy_now[op_rs1] ||
                    (!op_use_imm && busy_now[op_rs2]) ||
                    busy_now[op_rd];

    assign is_mul     = (op_code == op_mul);
    assign unit_ready = is_mul ? mul.ready : alu.ready;
    assign op_ready   = !hazard && unit_ready;
    assign accept     = op_valid && op_ready;

    always_comb begin
        set_mask = '0;
        if (accept && (op_rd != '0)) begin
            set_mask[op_rd] = 1'b1;
        end
    end

    // Scoreboard
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            busy <= busy_now | set_mask;
        end
    end

    // Operand read
    assign rs1       = op_rs1;
    assign rs2       = op_rs2;
    assign imm_ext   = {{(`XLEN - `IMM_W){op_imm[`IMM_W-1]}}, op_imm};
    assign operand_b = op_use_imm ? imm_ext : rdata2;

    // Dispatch, both units see the same payload
    assign alu.valid     = accept && !is_mul;
    assign alu.op        = op_code;
    assign alu.dst       = op_rd;
    assign alu.operand_a = rdata1;
    assign alu.operand_b = operand_b;

    assign mul.valid     = accept && is_mul;
    assign mul.op        = op_code;
    assign mul.dst       = op_rd;
    assign mul.operand_a = rdata1;
    assign mul.operand_b = operand_b;

endmodule

// ==== rtl/muldiv.sv ====
`include "cpu_config.svh"

module muldiv (
    input  logic      clk,
    input  logic      rst,
    fu_issue_if.unit  req,
    fu_wb_if.unit     wb
);
    import cpu_pkg::*;

    localparam int CNT_W = $clog2(`MUL_CYCLES + 1);

    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic             done;
    logic             step;
    xdata_t           acc;
    xdata_t           mcand;
    xdata_t           mplier;
    xdata_t           step_sum;
    reg_idx_t         dst_q;

    // Counter saturates at MUL_CYCLES, result then waits for grant
    assign done = busy && (cnt == CNT_W'(`MUL_CYCLES));
    assign step = busy && !done;

    assign req.ready = !busy;

    // Add the shifted multiplicand for each set bit of this group
    always_comb begin
        step_sum = acc;
        for (int i = 0; i < `MUL_BITS; i++) begin
            if (mplier[i]) begin
                step_sum = step_sum + (mcand << i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (req.valid && req.ready) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (done && wb.ready) begin
            busy <= 1'b0;
        end else if (step) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid && req.ready) begin
            acc    <= '0;
            mcand  <= req.operand_a;
            mplier <= req.operand_b;
            dst_q  <= req.dst;
        end else if (step) begin
            acc    <= step_sum;
            mcand  <= mcand << `MUL_BITS;
            mplier <= mplier >> `MUL_BITS;
        end
    end

    // Only the low XLEN bits of the product are kept
    assign wb.valid  = done;
    assign wb.dst    = dst_q;
    assign wb.result = acc;

endmodule

// ==== rtl/regfile.sv ====
`include "cpu_config.svh"

module regfile (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::reg_idx_t  rs1,
    input  cpu_pkg::reg_idx_t  rs2,
    output cpu_pkg::xdata_t    rdata1,
    output cpu_pkg::xdata_t    rdata2,
    input  cpu_pkg::rf_write_t wr
);
    import cpu_pkg::*;

    xdata_t regs [`NREGS];
    logic   wr_live;

    // x0 is never stored
    assign wr_live = wr.en && (wr.dst != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (wr_live) begin
            regs[wr.dst] <= wr.data;
        end
    end

    // Write-through so issue sees a result retiring this cycle
    always_comb begin
        if (rs1 == '0) begin
            rdata1 = '0;
        end else if (wr_live && (wr.dst == rs1)) begin
            rdata1 = wr.data;
        end else begin
            rdata1 = regs[rs1];
        end
        if (rs2 == '0) begin
            rdata2 = '0;
        end else if (wr_live && (wr.dst == rs2)) begin
            rdata2 = wr.data;
        end else begin
            rdata2 = regs[rs2];
        end
    end

endmodule

// ==== rtl/wb_arbiter.sv ====
module wb_arbiter (
    fu_wb_if.arbiter           mul_wb,
    fu_wb_if.arbiter           alu_wb,
    output cpu_pkg::rf_write_t wr
);
    import cpu_pkg::*;

    logic mul_grant;
    logic alu_grant;

    // Multiplier first, it has stalled issue the longest
    assign mul_grant = mul_wb.valid;
    assign alu_grant = alu_wb.valid && !mul_wb.valid;

    assign mul_wb.ready = mul_grant;
    assign alu_wb.ready = alu_grant;

    always_comb begin
        wr.en = mul_grant || alu_grant;
        if (mul_grant) begin
            wr.dst  = mul_wb.dst;
            wr.data = mul_wb.result;
        end else begin
            wr.dst  = alu_wb.dst;
            wr.data = alu_wb.result;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the cpu_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module cpu_core_tb

output=$(./obj_dir/Vcpu_core_tb 2>&1) || true
echo "$output"
if echo "$output" | grep -q "^Verification passed$"; then
    exit 0
fi
exit 1

// ==== tests/cpu_core_sva.sv ====
`include "cpu_config.svh"

module cpu_core_sva (
    input logic               clk,
    input logic               rst,
    input logic               op_valid,
    input logic               op_ready,
    input logic [3:0]         op_code,
    input logic [`REG_AW-1:0] op_rd,
    input logic [`REG_AW-1:0] op_rs1,
    input logic [`REG_AW-1:0] op_rs2,
    input logic [`IMM_W-1:0]  op_imm,
    input logic               op_use_imm,
    input logic               retire_valid,
    input logic [`REG_AW-1:0] retire_dst
);
    timeunit 1ns;
    timeprecision 100ps;

    // A stalled operation stays on the port unchanged
    property op_held_stable;
        @(posedge clk) disable iff (rst)
        (op_valid && !op_ready) |=>
            (op_valid && $stable({op_code, op_rd, op_rs1, op_rs2, op_imm, op_use_imm}));
    endproperty

    assert property (op_held_stable)
        else $error("op inputs changed while waiting for op_ready");

    assert property (@(posedge clk) (rst && $past(rst)) |-> !retire_valid)
        else $error("retire_valid high during reset");

    assert property (@(posedge clk) disable iff (rst) retire_valid |-> !$isunknown(retire_dst))
        else $error("retire_dst unknown on a retire");

endmodule

bind cpu_core cpu_core_sva sva0 (.*);

// ==== tests/cpu_core_tb.sv ====
`include "cpu_config.svh"

module cpu_core_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import cpu_pkg::*;

    localparam int RESET_CYCLES  = 10;
    localparam int MARGIN_CYCLES = 200;

    typedef struct {
        opcode_e           op;
        reg_idx_t          rd;
        reg_idx_t          rs1;
        reg_idx_t          rs2;
        logic [`IMM_W-1:0] imm;
        logic              use_imm;
    } row_t;

    logic clk;
    logic rst;
    logic op_valid;
    logic op_ready;
    logic [3:0] op_code;
    logic [`REG_AW-1:0] op_rd;
    logic [`REG_AW-1:0] op_rs1;
    logic [`REG_AW-1:0] op_rs2;
    logic [`IMM_W-1:0] op_imm;
    logic op_use_imm;
    logic retire_valid;
    logic [`REG_AW-1:0] retire_dst;
    logic [`XLEN-1:0] retire_data;

    row_t   rows[$];
    xdata_t model_regs[`NREGS];
    xdata_t exp_val[`NREGS];
    logic   pending[`NREGS];
    // Writes to x0 are never marked busy, so they queue in issue order
    xdata_t x0_q[$];
    int     issued;
    int     retired;

    cpu_core dut0 (.*);

    always #2 clk = ~clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, expected));
        end
    endtask

    task automatic add_row(input opcode_e op, input int rd, input int rs1, input int rs2,
                           input int imm, input int use_imm);
        row_t r;
        r.op      = op;
        r.rd      = reg_idx_t'(rd);
        r.rs1     = reg_idx_t'(rs1);
        r.rs2     = reg_idx_t'(rs2);
        r.imm     = `IMM_W'(imm);
        r.use_imm = (use_imm != 0);
        rows.push_back(r);
    endtask

    function automatic xdata_t alu_model(input opcode_e op, input xdata_t a, input xdata_t b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << b[5:0];
            op_srl:  return a >> b[5:0];
            op_mul:  return a * b;
            default: return '0;
        endcase
    endfunction

    // Expected value is fixed when the operation is accepted
    task automatic record_issue();
        xdata_t a;
        xdata_t b;
        xdata_t res;
        a = model_regs[op_rs1];
        b = op_use_imm ? {{(`XLEN - `IMM_W){op_imm[`IMM_W-1]}}, op_imm} : model_regs[op_rs2];
        res = alu_model(opcode_e'(op_code), a, b);
        if (op_rd == '0) begin
            x0_q.push_back(res);
        end else begin
            model_regs[op_rd] = res;
            exp_val[op_rd]    = res;
            pending[op_rd]    = 1'b1;
        end
        issued++;
    endtask

    task automatic check_retire();
        if (retire_dst == '0 && x0_q.size() == 0) begin
            fail_run("A write to x0 retired with no such operation pending");
        end else if (retire_dst != '0 && !pending[retire_dst]) begin
            fail_run($sformatf("A write to x%0d retired with no operation pending", retire_dst));
        end else if (retire_dst == '0) begin
            check_value("retire_data", retire_data, x0_q.pop_front());
        end else begin
            check_value("retire_data", retire_data, exp_val[retire_dst]);
            pending[retire_dst] = 1'b0;
        end
        retired++;
    endtask

    // Retire monitor checks before recording a same-cycle issue
    always @(posedge clk) begin
        if (!rst) begin
            if (retire_valid) begin
                check_retire();
            end
            if (op_valid && op_ready) begin
                record_issue();
            end
        end
    end

    initial begin
        #1;
        repeat (rows.size() * (`MUL_CYCLES + 8) + RESET_CYCLES + MARGIN_CYCLES) @(posedge clk);
        fail_run("Timeout: the operations did not all retire in time");
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        op_valid = 1'b0;
        op_code = '0;
        op_rd = '0;
        op_rs1 = '0;
        op_rs2 = '0;
        op_imm = '0;
        op_use_imm = 1'b0;
        issued = 0;
        retired = 0;
        void'($urandom(32'h17c1_02e6));
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
            exp_val[i] = '0;
            pending[i] = 1'b0;
        end
        add_row(op_add, 1, 0, 0, 0, 0);
        // Immediates and every ALU opcode
        add_row(op_add, 1, 0, 0, 'h7ff, 1);
        add_row(op_add, 2, 0, 0, 'h800, 1);
        add_row(op_add, 3, 0, 0, 40, 1);
        add_row(op_sub, 4, 1, 2, 0, 0);
        add_row(op_and, 5, 2, 0, 'hf0f, 1);
        add_row(op_or, 6, 1, 2, 0, 0);
        add_row(op_xor, 7, 1, 0, 'habc, 1);
        add_row(op_sll, 8, 2, 3, 0, 0);
        add_row(op_srl, 9, 2, 0, 33, 1);
        add_row(op_sll, 10, 1, 0, 63, 1);
        add_row(op_srl, 11, 7, 0, 'hfff, 1);
        // Dependent chain through both units
        add_row(op_add, 12, 8, 0, 1, 1);
        add_row(op_xor, 13, 12, 4, 0, 0);
        add_row(op_sll, 14, 13, 0, 3, 1);
        add_row(op_mul, 15, 14, 13, 0, 0);
        add_row(op_sub, 16, 15, 1, 0, 0);
        add_row(op_mul, 16, 16, 16, 0, 0);
        // Wide random multiplier operands
        add_row(op_add, 17, 0, 0, int'(`IMM_W'($urandom)), 1);
        add_row(op_add, 18, 0, 0, int'(`IMM_W'($urandom)), 1);
        add_row(op_sll, 19, 17, 0, 37, 1);
        add_row(op_xor, 20, 19, 18, 0, 0);
        add_row(op_mul, 21, 20, 20, 0, 0);
        add_row(op_mul, 22, 21, 16, 0, 0);
        // ALU work overtaking a multiply
        add_row(op_mul, 23, 22, 21, 0, 0);
        add_row(op_add, 24, 1, 0, 5, 1);
        add_row(op_sub, 25, 2, 3, 0, 0);
        add_row(op_or, 26, 4, 0, 'h0f0, 1);
        add_row(op_srl, 27, 5, 0, 2, 1);
        add_row(op_add, 28, 23, 24, 0, 0);
        // x0 as destination
        add_row(op_add, 0, 1, 2, 0, 0);
        add_row(op_xor, 0, 7, 0, 1, 1);
        add_row(op_add, 29, 0, 0, 0, 0);
        add_row(op_or, 30, 0, 0, 'h123, 1);

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("retire_valid", retire_valid, 1'b0);

        foreach (rows[i]) begin
            op_valid   <= 1'b1;
            op_code    <= rows[i].op;
            op_rd      <= rows[i].rd;
            op_rs1     <= rows[i].rs1;
            op_rs2     <= rows[i].rs2;
            op_imm     <= rows[i].imm;
            op_use_imm <= rows[i].use_imm;
            @(posedge clk);
            while (!op_ready) @(posedge clk);
            if (($urandom % 4) == 0) begin
                op_valid <= 1'b0;
                @(posedge clk);
            end
        end
        op_valid <= 1'b0;

        while (issued < rows.size() || retired < issued) @(posedge clk);
        @(posedge clk);
        for (int i = 0; i < `NREGS; i++) begin
            check_value($sformatf("regs[%0d]", i), dut0.rf0.regs[i], model_regs[i]);
        end

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
rtl/cpu_pkg.sv
rtl/fu_if.sv
rtl/regfile.sv
rtl/issue.sv
rtl/int_pipe.sv
rtl/muldiv.sv
rtl/wb_arbiter.sv
rtl/cpu_core.sv
tests/cpu_core_sva.sv
tests/cpu_core_tb.sv
